//--- hdl/dbg_trig_bank.sv
`default_nettype none

module dbg_trig_bank #(
  parameter int NUM_TRIGGERS = 1
) (
  input  logic                                          clk,
  input  logic                                          rst_n_i,
  input  dbg_trig_pkg::csr_wr_t                         wr_i,  // Already legalised
  output dbg_trig_pkg::csr_rd_t                         rd_o,
  output dbg_trig_pkg::trig_cfg_t [NUM_TRIGGERS-1:0]    cfg_o  // Every trigger, for matching
);

  logic [dbg_trig_pkg::XLEN-1:0] tselect_q;
  logic [dbg_trig_pkg::XLEN-1:0] tdata1_q [NUM_TRIGGERS];
  logic [dbg_trig_pkg::XLEN-1:0] tdata2_q [NUM_TRIGGERS];
  logic [NUM_TRIGGERS-1:0]       tdata1_we; // Per trigger write enables
  logic [NUM_TRIGGERS-1:0]       tdata2_we;

  // Trigger select
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tselect_q <= '0;
    end else if (wr_i.tselect_we) begin
      tselect_q <= wr_i.wdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Per trigger registers
  ////////////////////////////////////////////////////////////

  for (genvar idx = 0; idx < NUM_TRIGGERS; idx++) begin : gen_trig
    // Only the selected trigger takes the write
    assign tdata1_we[idx] = wr_i.tdata1_we && (tselect_q == idx);
    assign tdata2_we[idx] = wr_i.tdata2_we && (tselect_q == idx);

    always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
        tdata1_q[idx] <= dbg_trig_pkg::TDATA1_RST_VAL; // Disabled out of reset
        tdata2_q[idx] <= '0;
      end else begin
        if (tdata1_we[idx]) begin
          tdata1_q[idx] <= wr_i.wdata;
        end
        if (tdata2_we[idx]) begin
          tdata2_q[idx] <= wr_i.wdata;
        end
      end
    end

    assign cfg_o[idx].tdata1 = tdata1_q[idx];
    assign cfg_o[idx].tdata2 = tdata2_q[idx];
  end

  // Readback of the selected trigger
  always_comb begin
    rd_o.tselect = tselect_q;
    rd_o.tdata1  = tdata1_q[0];
    rd_o.tdata2  = tdata2_q[0];
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      if (tselect_q == i) begin
        rd_o.tdata1 = tdata1_q[i];
        rd_o.tdata2 = tdata2_q[i];
      end
    end
  end

  // WARL upstream must never let the index run past the bank
  a_tselect_range: assert property (@(posedge clk) disable iff (!rst_n_i)
                                    tselect_q < NUM_TRIGGERS)
    else $error("tselect 0x%0h beyond %0d triggers", tselect_q, NUM_TRIGGERS);

endmodule

`default_nettype wire

//--- hdl/dbg_trig_match.sv
`default_nettype none

module dbg_trig_match (
  input  dbg_trig_pkg::trig_cfg_t       cfg_i,
  input  dbg_trig_pkg::if_req_t         if_req_i,
  input  dbg_trig_pkg::lsu_req_t        lsu_req_i,
  input  logic [dbg_trig_pkg::XLEN-1:0] lsu_low_i,  // Lowest byte of the access
  input  logic [dbg_trig_pkg::XLEN-1:0] lsu_high_i, // Highest byte of the access
  input  dbg_trig_pkg::wb_exc_t         wb_exc_i,
  output dbg_trig_pkg::trig_hit_t       hit_o
);

  logic [dbg_trig_pkg::XLEN-1:0] tdata1;
  logic [dbg_trig_pkg::XLEN-1:0] tdata2;
  logic [3:0]                    match;      // Already legal, see WARL block
  logic                          is_mc6;
  logic                          is_etrig;
  logic                          if_addr_match;
  logic [3:0]                    byte_match; // Enabled bytes that hit tdata2[1:0]
  logic                          lsu_addr_match;
  logic                          lsu_dir_en; // Load or store enabled for this access
  logic                          exc_code_match;

  // M and U enables against the stage privilege
  function automatic logic priv_en(logic m_en, logic u_en, dbg_trig_pkg::priv_lvl_t lvl);
    return (m_en && (lvl == dbg_trig_pkg::PRIV_LVL_M)) ||
           (u_en && (lvl == dbg_trig_pkg::PRIV_LVL_U));
  endfunction

  assign tdata1   = cfg_i.tdata1;
  assign tdata2   = cfg_i.tdata2;
  assign match    = tdata1[dbg_trig_pkg::MC6_MATCH_HIGH:dbg_trig_pkg::MC6_MATCH_LOW];
  assign is_mc6   = tdata1[dbg_trig_pkg::TDATA1_TYPE_HIGH:dbg_trig_pkg::TDATA1_TYPE_LOW] ==
                    dbg_trig_pkg::TTYPE_MCONTROL6;
  assign is_etrig = tdata1[dbg_trig_pkg::TDATA1_TYPE_HIGH:dbg_trig_pkg::TDATA1_TYPE_LOW] ==
                    dbg_trig_pkg::TTYPE_ETRIGGER;

  ////////////////////////////////////////////////////////////
  // Instruction address (IF)
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (match)
      dbg_trig_pkg::MATCH_EQ: if_addr_match = (if_req_i.pc == tdata2);
      dbg_trig_pkg::MATCH_GE: if_addr_match = (if_req_i.pc >= tdata2);
      dbg_trig_pkg::MATCH_LT: if_addr_match = (if_req_i.pc <  tdata2);
      default:                if_addr_match = 1'b0;
    endcase
  end

  // Table pointers are data, never a fetch match
  assign hit_o.if_hit = is_mc6 && tdata1[dbg_trig_pkg::MC6_EXECUTE] && !if_req_i.ptr &&
                        priv_en(tdata1[dbg_trig_pkg::MC6_M], tdata1[dbg_trig_pkg::MC6_U],
                                if_req_i.priv) &&
                        if_addr_match;

  ////////////////////////////////////////////////////////////
  // Load/store address (EX)
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      byte_match[b] = lsu_req_i.be[b] && (2'(b) == tdata2[1:0]);
    end
  end

  // EQ needs the word and one enabled byte, GE/LT take the span edge
  always_comb begin
    case (match)
      dbg_trig_pkg::MATCH_EQ: lsu_addr_match = (lsu_req_i.addr[31:2] == tdata2[31:2]) &&
                                               (|byte_match);
      dbg_trig_pkg::MATCH_GE: lsu_addr_match = (lsu_high_i >= tdata2);
      dbg_trig_pkg::MATCH_LT: lsu_addr_match = (lsu_low_i  <  tdata2);
      default:                lsu_addr_match = 1'b0;
    endcase
  end

  assign lsu_dir_en = (tdata1[dbg_trig_pkg::MC6_LOAD]  && !lsu_req_i.we) ||
                      (tdata1[dbg_trig_pkg::MC6_STORE] &&  lsu_req_i.we);

  assign hit_o.ex_hit = is_mc6 && lsu_req_i.valid && lsu_dir_en &&
                        priv_en(tdata1[dbg_trig_pkg::MC6_M], tdata1[dbg_trig_pkg::MC6_U],
                                lsu_req_i.priv) &&
                        lsu_addr_match;

  ////////////////////////////////////////////////////////////
  // Exception (WB)
  ////////////////////////////////////////////////////////////

  // tdata2 is a bitmap of causes, 32 and up never hit
  assign exc_code_match = (wb_exc_i.cause < 11'd32) && tdata2[wb_exc_i.cause[4:0]];

  assign hit_o.wb_hit = is_etrig && wb_exc_i.exc && exc_code_match &&
                        priv_en(tdata1[dbg_trig_pkg::ETRIG_M], tdata1[dbg_trig_pkg::ETRIG_U],
                                wb_exc_i.priv);

endmodule

`default_nettype wire

//--- hdl/dbg_trig_match_array.sv
`default_nettype none

module dbg_trig_match_array #(
  parameter int NUM_TRIGGERS = 1
) (
  input  dbg_trig_pkg::trig_cfg_t [NUM_TRIGGERS-1:0] cfg_i,
  input  dbg_trig_pkg::if_req_t                      if_req_i,
  input  dbg_trig_pkg::lsu_req_t                     lsu_req_i,
  input  dbg_trig_pkg::wb_exc_t                      wb_exc_i,
  input  logic                                       debug_mode_i, // Core halted
  output dbg_trig_pkg::trig_hit_t                    hits_o
);

  logic [1:0]                                low_lsb;  // Lowest enabled byte
  logic [1:0]                                high_lsb; // Highest enabled byte
  logic [dbg_trig_pkg::XLEN-1:0]             lsu_low;
  logic [dbg_trig_pkg::XLEN-1:0]             lsu_high;
  dbg_trig_pkg::trig_hit_t [NUM_TRIGGERS-1:0] trig_hit; // One entry per trigger
  dbg_trig_pkg::trig_hit_t                   hit_any;

  ////////////////////////////////////////////////////////////
  // Byte span of the access
  ////////////////////////////////////////////////////////////

  always_comb begin
    low_lsb  = 2'b00; // No byte enabled leaves both at 0
    high_lsb = 2'b00;
    for (int b = 0; b < 4; b++) begin
      if (lsu_req_i.be[b]) begin
        high_lsb = 2'(b); // Last set bit wins
      end
    end
    for (int b = 3; b >= 0; b--) begin
      if (lsu_req_i.be[b]) begin
        low_lsb = 2'(b);
      end
    end
  end

  assign lsu_low  = {lsu_req_i.addr[31:2], low_lsb};
  assign lsu_high = {lsu_req_i.addr[31:2], high_lsb};

  for (genvar idx = 0; idx < NUM_TRIGGERS; idx++) begin : gen_match
    dbg_trig_match dbg_trig_match_inst (
      .cfg_i      (cfg_i[idx]),
      .if_req_i   (if_req_i),
      .lsu_req_i  (lsu_req_i),
      .lsu_low_i  (lsu_low),
      .lsu_high_i (lsu_high),
      .wb_exc_i   (wb_exc_i),
      .hit_o      (trig_hit[idx])
    );
  end

  // Any trigger raises the stage hit
  always_comb begin
    hit_any = '0;
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      hit_any = hit_any | trig_hit[i];
    end
  end

  assign hits_o = debug_mode_i ? '0 : hit_any; // Triggers are off while halted

  a_no_hit_in_dmode: assert final ((debug_mode_i !== 1'b1) || (hits_o == '0))
    else $error("Trigger hit 0x%0h in debug mode", hits_o);

endmodule

`default_nettype wire

//--- hdl/dbg_trig_pkg.sv
`default_nettype none

package dbg_trig_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and trigger encodings
  ////////////////////////////////////////////////////////////

  localparam int XLEN = 32; // Address and data width

  localparam logic [3:0] TTYPE_ETRIGGER  = 4'h5; // Exception trigger
  localparam logic [3:0] TTYPE_MCONTROL6 = 4'h6; // Address match trigger
  localparam logic [3:0] TTYPE_DISABLED  = 4'hF; // Trigger switched off

  localparam logic [XLEN-1:0] TDATA1_RST_VAL  = 32'hF800_0000; // Disabled type, dmode set
  localparam logic [XLEN-1:0] ETRIG_CODE_MASK = 32'h0000_09AF; // Implemented exception codes

  // Legal match codes, everything else resolves to EQ
  localparam logic [3:0] MATCH_EQ = 4'h0;
  localparam logic [3:0] MATCH_GE = 4'h2;
  localparam logic [3:0] MATCH_LT = 4'h3;

  // tdata1 field positions
  localparam int TDATA1_TYPE_HIGH  = 31;
  localparam int TDATA1_TYPE_LOW   = 28;
  localparam int MC6_MATCH_HIGH    = 10;
  localparam int MC6_MATCH_LOW     = 7;
  localparam int MC6_M             = 6;
  localparam int MC6_U             = 3;
  localparam int MC6_EXECUTE       = 2;
  localparam int MC6_STORE         = 1;
  localparam int MC6_LOAD          = 0;
  localparam int ETRIG_M           = 9;
  localparam int ETRIG_U           = 6;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  typedef struct packed {
    logic [XLEN-1:0] wdata;      // Raw write data, or resolved next value
    logic            tselect_we;
    logic            tdata1_we;
    logic            tdata2_we;
  } csr_wr_t;

  typedef struct packed {
    logic [XLEN-1:0] tselect;
    logic [XLEN-1:0] tdata1;     // Of the selected trigger
    logic [XLEN-1:0] tdata2;
  } csr_rd_t;

  typedef struct packed {
    logic [XLEN-1:0] tdata1;
    logic [XLEN-1:0] tdata2;
  } trig_cfg_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;         // IF stage PC
    logic            ptr;        // Fetch is a table pointer, not an instruction
    priv_lvl_t       priv;
  } if_req_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] addr;
    logic            we;         // Store when set
    logic [3:0]      be;
    priv_lvl_t       priv;
  } lsu_req_t;

  typedef struct packed {
    logic            exc;        // Exception in WB
    logic [10:0]     cause;
    priv_lvl_t       priv;
  } wb_exc_t;

  typedef struct packed {
    logic if_hit;
    logic ex_hit;
    logic wb_hit;
  } trig_hit_t;

  // Match field WARL, only 0, 2 and 3 are kept
  function automatic logic [3:0] resolve_match(logic [3:0] match);
    return ((match == MATCH_GE) || (match == MATCH_LT)) ? match : MATCH_EQ;
  endfunction

endpackage

`default_nettype wire

//--- hdl/dbg_trig_warl.sv
`default_nettype none

module dbg_trig_warl #(
  parameter int NUM_TRIGGERS = 1
) (
  input  dbg_trig_pkg::csr_wr_t csr_wr_i, // Raw host write
  input  dbg_trig_pkg::csr_rd_t cur_i,    // Current register contents
  output dbg_trig_pkg::csr_wr_t wr_o      // Legal next value, strobes unchanged
);

  logic [dbg_trig_pkg::XLEN-1:0] wdata;
  logic [dbg_trig_pkg::XLEN-1:0] tselect_n;
  logic [dbg_trig_pkg::XLEN-1:0] tdata1_n;
  logic [dbg_trig_pkg::XLEN-1:0] tdata2_n;
  logic [3:0]                    wr_type;  // Type field being written
  logic [3:0]                    cur_type; // Type of the selected trigger now
  logic                          etrig_ok; // tdata2 only holds implemented codes

  assign wdata    = csr_wr_i.wdata;
  assign wr_type  = wdata[dbg_trig_pkg::TDATA1_TYPE_HIGH:dbg_trig_pkg::TDATA1_TYPE_LOW];
  assign cur_type = cur_i.tdata1[dbg_trig_pkg::TDATA1_TYPE_HIGH:dbg_trig_pkg::TDATA1_TYPE_LOW];
  assign etrig_ok = ~|(cur_i.tdata2 & ~dbg_trig_pkg::ETRIG_CODE_MASK);

  // Out of range index keeps the old selection
  assign tselect_n = (wdata < NUM_TRIGGERS) ? wdata : cur_i.tselect;

  ////////////////////////////////////////////////////////////
  // tdata1 legalisation
  ////////////////////////////////////////////////////////////

  always_comb begin
    tdata1_n = dbg_trig_pkg::TDATA1_RST_VAL; // Unknown types end up disabled
    if (wr_type == dbg_trig_pkg::TTYPE_MCONTROL6) begin
      tdata1_n = {
        dbg_trig_pkg::TTYPE_MCONTROL6,
        1'b1,                    // dmode
        11'b0,                   // Unimplemented fields 26:16
        4'b0001,                 // action, enter debug
        1'b0,                    // chain
        dbg_trig_pkg::resolve_match(
          wdata[dbg_trig_pkg::MC6_MATCH_HIGH:dbg_trig_pkg::MC6_MATCH_LOW]),
        wdata[dbg_trig_pkg::MC6_M],
        2'b00,                   // No S mode
        wdata[dbg_trig_pkg::MC6_U],
        wdata[dbg_trig_pkg::MC6_EXECUTE],
        wdata[dbg_trig_pkg::MC6_STORE],
        wdata[dbg_trig_pkg::MC6_LOAD]
      };
    end else if ((wr_type == dbg_trig_pkg::TTYPE_ETRIGGER) && etrig_ok) begin
      tdata1_n = {
        dbg_trig_pkg::TTYPE_ETRIGGER,
        1'b1,                    // dmode
        17'b0,                   // hit, vs, vu and reserved 26:10
        wdata[dbg_trig_pkg::ETRIG_M],
        2'b00,                   // No S mode
        wdata[dbg_trig_pkg::ETRIG_U],
        6'b000001                // action, enter debug
      };
    end
  end

  // Etrigger can only hold implemented codes
  assign tdata2_n = (cur_type == dbg_trig_pkg::TTYPE_ETRIGGER) ?
                    (wdata & dbg_trig_pkg::ETRIG_CODE_MASK) : wdata;

  // Single data word carries whichever register is strobed
  always_comb begin
    wr_o = csr_wr_i;
    if (csr_wr_i.tselect_we) begin
      wr_o.wdata = tselect_n;
    end else if (csr_wr_i.tdata1_we) begin
      wr_o.wdata = tdata1_n;
    end else if (csr_wr_i.tdata2_we) begin
      wr_o.wdata = tdata2_n;
    end
  end

  // Host side contract
  a_one_strobe: assert final ($isunknown({csr_wr_i.tselect_we, csr_wr_i.tdata1_we,
                                          csr_wr_i.tdata2_we}) ||
                              $onehot0({csr_wr_i.tselect_we, csr_wr_i.tdata1_we,
                                        csr_wr_i.tdata2_we}))
    else $error("More than one trigger CSR strobe in a cycle");

  a_legal_type: assert final ((wr_o.tdata1_we !== 1'b1) ||
                              (wr_o.wdata[31:28] inside {dbg_trig_pkg::TTYPE_ETRIGGER,
                                                         dbg_trig_pkg::TTYPE_MCONTROL6,
                                                         dbg_trig_pkg::TTYPE_DISABLED}))
    else $error("Illegal trigger type 0x%0h reaches tdata1", wr_o.wdata[31:28]);

endmodule

`default_nettype wire

//--- hdl/dbg_triggers.sv
`default_nettype none

module dbg_triggers #(
  parameter int NUM_TRIGGERS = 2 // 1 to 4
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  dbg_trig_pkg::csr_wr_t   csr_wr_i,     // Host CSR write, one strobe at a time
  output dbg_trig_pkg::csr_rd_t   csr_rd_o,
  input  dbg_trig_pkg::if_req_t   if_req_i,     // IF stage
  input  dbg_trig_pkg::lsu_req_t  lsu_req_i,    // EX stage
  input  dbg_trig_pkg::wb_exc_t   wb_exc_i,     // WB stage
  input  logic                    debug_mode_i,
  output dbg_trig_pkg::trig_hit_t hits_o
);

  dbg_trig_pkg::csr_wr_t                     wr_legal; // Legalised write into the bank
  dbg_trig_pkg::trig_cfg_t [NUM_TRIGGERS-1:0] trig_cfg; // Live trigger contents

  ////////////////////////////////////////////////////////////
  // CSR side
  ////////////////////////////////////////////////////////////

  dbg_trig_warl #(
    .NUM_TRIGGERS (NUM_TRIGGERS)
  ) dbg_trig_warl_inst (
    .csr_wr_i (csr_wr_i),
    .cur_i    (csr_rd_o), // Current values for the hold and etrigger rules
    .wr_o     (wr_legal)
  );

  dbg_trig_bank #(
    .NUM_TRIGGERS (NUM_TRIGGERS)
  ) dbg_trig_bank_inst (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .wr_i    (wr_legal),
    .rd_o    (csr_rd_o),
    .cfg_o   (trig_cfg)
  );

  ////////////////////////////////////////////////////////////
  // Match side
  ////////////////////////////////////////////////////////////

  dbg_trig_match_array #(
    .NUM_TRIGGERS (NUM_TRIGGERS)
  ) dbg_trig_match_array_inst (
    .cfg_i        (trig_cfg),
    .if_req_i     (if_req_i),
    .lsu_req_i    (lsu_req_i),
    .wb_exc_i     (wb_exc_i),
    .debug_mode_i (debug_mode_i),
    .hits_o       (hits_o)
  );

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
hdl/dbg_trig_pkg.sv
hdl/dbg_trig_warl.sv
hdl/dbg_trig_bank.sv
hdl/dbg_trig_match.sv
hdl/dbg_trig_match_array.sv
hdl/dbg_triggers.sv
verif/tb_dbg_triggers.sv

//--- include/tb_dbg_trig_checks.svh
`ifndef TB_DBG_TRIG_CHECKS_SVH
`define TB_DBG_TRIG_CHECKS_SVH

////////////////////////////////////////////////////////////
// Error counters and compare tasks
////////////////////////////////////////////////////////////

int rd_errors  = 0; // CSR readback mismatches
int hit_errors = 0; // Hit output mismatches

localparam int CSR_TSELECT = 0;
localparam int CSR_TDATA1  = 1;
localparam int CSR_TDATA2  = 2;

task automatic check_rd(input dbg_trig_pkg::csr_rd_t exp, input string what);
  if (csr_rd.tselect !== exp.tselect) begin
    rd_errors++;
    $display("mismatch csr_rd_o.tselect (%s): got 0x%08h expected 0x%08h",
             what, csr_rd.tselect, exp.tselect);
  end
  if (csr_rd.tdata1 !== exp.tdata1) begin
    rd_errors++;
    $display("mismatch csr_rd_o.tdata1 (%s): got 0x%08h expected 0x%08h",
             what, csr_rd.tdata1, exp.tdata1);
  end
  if (csr_rd.tdata2 !== exp.tdata2) begin
    rd_errors++;
    $display("mismatch csr_rd_o.tdata2 (%s): got 0x%08h expected 0x%08h",
             what, csr_rd.tdata2, exp.tdata2);
  end
endtask

task automatic check_hits(input dbg_trig_pkg::trig_hit_t exp, input string what);
  if (hits !== exp) begin
    hit_errors++;
    $display("mismatch hits_o (%s): got 0x%0h expected 0x%0h", what, hits, exp);
  end
endtask

////////////////////////////////////////////////////////////
// Stimulus helpers
////////////////////////////////////////////////////////////

task automatic next_cycle();
  @(posedge clk);
  #1; // Drive point after the edge
endtask

// One cycle strobe, register updates at the next edge
task automatic write_csr(input int csr, input logic [31:0] data);
  csr_wr       = '0;
  csr_wr.wdata = data;
  case (csr)
    CSR_TSELECT: csr_wr.tselect_we = 1'b1;
    CSR_TDATA1:  csr_wr.tdata1_we  = 1'b1;
    default:     csr_wr.tdata2_we  = 1'b1;
  endcase
  next_cycle();
  csr_wr = '0;
endtask

task automatic clear_requests();
  if_req     = '0;
  lsu_req    = '0;
  wb_exc     = '0;
  debug_mode = 1'b0;
endtask

task automatic drive_lsu(input logic [31:0] addr, input logic we, input logic [3:0] be);
  lsu_req.valid = 1'b1;
  lsu_req.addr  = addr;
  lsu_req.we    = we;
  lsu_req.be    = be;
  lsu_req.priv  = dbg_trig_pkg::PRIV_LVL_M;
endtask

task automatic drive_exc(input logic exc, input logic [10:0] cause,
                         input dbg_trig_pkg::priv_lvl_t priv);
  wb_exc.exc   = exc;
  wb_exc.cause = cause;
  wb_exc.priv  = priv;
endtask

// Hits are combinational, so look half a cycle later
task automatic sample_hits(input dbg_trig_pkg::trig_hit_t exp, input string what);
  #1;
  check_hits(exp, what);
  next_cycle();
endtask

`endif

//--- verif/tb_dbg_triggers.sv
`default_nettype none

module tb_dbg_triggers;

  localparam int NUM_TRIGGERS = 2;
  localparam int CLK_PERIOD   = 4;
  localparam int RST_CYCLES   = 16;
  localparam int NUM_TESTS    = 6;

  localparam logic [31:0] RST_VAL    = dbg_trig_pkg::TDATA1_RST_VAL;
  localparam logic [31:0] MC6_BASE   = 32'h6800_1000; // Type 6, dmode, action 1
  localparam logic [31:0] ETRIG_BASE = 32'h5800_0001; // Type 5, dmode, action 1

  localparam dbg_trig_pkg::trig_hit_t NO_HIT = 3'b000;
  localparam dbg_trig_pkg::trig_hit_t HIT_IF = 3'b100;
  localparam dbg_trig_pkg::trig_hit_t HIT_EX = 3'b010;
  localparam dbg_trig_pkg::trig_hit_t HIT_WB = 3'b001;

  logic                    clk = 1'b0;
  logic                    rst_n;
  dbg_trig_pkg::csr_wr_t   csr_wr;
  dbg_trig_pkg::csr_rd_t   csr_rd;
  dbg_trig_pkg::if_req_t   if_req;
  dbg_trig_pkg::lsu_req_t  lsu_req;
  dbg_trig_pkg::wb_exc_t   wb_exc;
  logic                    debug_mode;
  dbg_trig_pkg::trig_hit_t hits;
  integer                  seed = 32'h4dbc; // Seed of the address stream

  `include "tb_dbg_trig_checks.svh"

  always #(CLK_PERIOD / 2) clk = ~clk;

  dbg_triggers #(
    .NUM_TRIGGERS (NUM_TRIGGERS)
  ) dbg_triggers_inst (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .csr_wr_i     (csr_wr),
    .csr_rd_o     (csr_rd),
    .if_req_i     (if_req),
    .lsu_req_i    (lsu_req),
    .wb_exc_i     (wb_exc),
    .debug_mode_i (debug_mode),
    .hits_o       (hits)
  );

  function automatic dbg_trig_pkg::csr_rd_t rd_value(input logic [31:0] sel, t1, t2);
    return {sel, t1, t2};
  endfunction

  // PC rule per match code
  function automatic logic pc_match(input logic [3:0] mode, input logic [31:0] pc, bound);
    case (mode)
      dbg_trig_pkg::MATCH_GE: return pc >= bound;
      dbg_trig_pkg::MATCH_LT: return pc < bound;
      default:                return pc == bound;
    endcase
  endfunction

  function automatic dbg_trig_pkg::priv_lvl_t random_priv();
    return ($random(seed) & 1) ? dbg_trig_pkg::PRIV_LVL_M : dbg_trig_pkg::PRIV_LVL_U;
  endfunction

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    check_rd(rd_value(0, RST_VAL, 0), "trigger 0 after reset");
    write_csr(CSR_TSELECT, 1);
    check_rd(rd_value(1, RST_VAL, 0), "trigger 1 after reset");
    write_csr(CSR_TSELECT, 0);
    for (int i = 0; i < 20; i++) begin // Nothing armed so nothing fires
      if_req.pc   = $random(seed);
      if_req.ptr  = $random(seed);
      if_req.priv = random_priv();
      drive_lsu($random(seed), $random(seed), $random(seed));
      drive_exc(1'b1, 11'($random(seed) & 31), random_priv());
      sample_hits(NO_HIT, "random request after reset");
    end
    clear_requests();
  endtask

  task automatic tselect_and_storage();
    write_csr(CSR_TSELECT, 1);
    write_csr(CSR_TSELECT, 5); // Index beyond the bank keeps the old one
    check_rd(rd_value(1, RST_VAL, 0), "tselect out of range");
    write_csr(CSR_TDATA2, 32'h1234_5678);
    write_csr(CSR_TSELECT, 0);
    write_csr(CSR_TDATA2, 32'h8765_4320);
    check_rd(rd_value(0, RST_VAL, 32'h8765_4320), "trigger 0 tdata2");
    write_csr(CSR_TSELECT, 1);
    check_rd(rd_value(1, RST_VAL, 32'h1234_5678), "trigger 1 tdata2");
    write_csr(CSR_TSELECT, 0);
  endtask

  task automatic tdata1_legalise();
    write_csr(CSR_TDATA2, 0);
    write_csr(CSR_TDATA1, 32'h6000_00C4); // Match code 1, M, execute
    check_rd(rd_value(0, MC6_BASE | 32'h44, 0), "mcontrol6 match 1");
    write_csr(CSR_TDATA1, 32'h6FFF_FFFF); // Junk fields and match 15
    check_rd(rd_value(0, MC6_BASE | 32'h4F, 0), "mcontrol6 junk fields");
    write_csr(CSR_TDATA1, 32'h2000_0044); // Legacy mcontrol
    check_rd(rd_value(0, RST_VAL, 0), "type 2");
    write_csr(CSR_TDATA1, 32'h9000_0000);
    check_rd(rd_value(0, RST_VAL, 0), "type 9");
  endtask

  task automatic instr_addr_match();
    logic [3:0]  modes [3];
    logic [31:0] base;
    logic [31:0] pc;
    modes = '{dbg_trig_pkg::MATCH_EQ, dbg_trig_pkg::MATCH_GE, dbg_trig_pkg::MATCH_LT};
    base  = $random(seed);
    clear_requests();
    write_csr(CSR_TDATA2, base);
    foreach (modes[m]) begin
      write_csr(CSR_TDATA1, 32'h6000_0044 | (32'(modes[m]) << 7)); // M and execute
      for (int i = 0; i < 12; i++) begin
        pc          = (i == 0) ? base : $random(seed); // Boundary first
        if_req.pc   = pc;
        if_req.ptr  = 1'b0;
        if_req.priv = dbg_trig_pkg::PRIV_LVL_M;
        sample_hits(pc_match(modes[m], pc, base) ? HIT_IF : NO_HIT, "PC compare");
      end
    end
    write_csr(CSR_TDATA1, 32'h6000_0044);
    if_req.priv = dbg_trig_pkg::PRIV_LVL_U;
    if_req.pc   = base;
    sample_hits(NO_HIT, "PC in U mode");
    if_req.priv = dbg_trig_pkg::PRIV_LVL_M;
    if_req.ptr  = 1'b1;
    sample_hits(NO_HIT, "PC pointer fetch");
    if_req.ptr = 1'b0;
    debug_mode = 1'b1;
    sample_hits(NO_HIT, "PC in debug mode");
    debug_mode = 1'b0;
    sample_hits(HIT_IF, "PC back out of debug mode");
    clear_requests();
    write_csr(CSR_TDATA1, 0); // Disarm
  endtask

  task automatic lsu_addr_match();
    logic [31:0] word;
    word = $random(seed) & 32'hFFFF_FFF0; // Room above for the span
    write_csr(CSR_TSELECT, 1);
    write_csr(CSR_TDATA2, word | 32'd2);
    write_csr(CSR_TDATA1, 32'h6000_0043); // EQ, M, load and store
    drive_lsu(word, 1'b0, 4'b0100);
    sample_hits(HIT_EX, "EQ on enabled byte");
    drive_lsu(word | 32'd1, 1'b0, 4'b0011);
    sample_hits(NO_HIT, "EQ byte not enabled");
    drive_lsu(word, 1'b1, 4'b1100);
    sample_hits(HIT_EX, "EQ store");
    drive_lsu(word + 32'd4, 1'b0, 4'b0100);
    sample_hits(NO_HIT, "EQ other word");
    drive_lsu(word, 1'b0, 4'b0000);
    sample_hits(NO_HIT, "EQ no byte enabled");
    drive_lsu(word, 1'b0, 4'b0100);
    lsu_req.valid = 1'b0;
    sample_hits(NO_HIT, "EQ not valid");
    write_csr(CSR_TDATA1, 32'h6000_0143); // GE
    check_rd(rd_value(1, MC6_BASE | 32'h143, word | 32'd2), "GE readback");
    drive_lsu(word, 1'b0, 4'b0011);
    sample_hits(NO_HIT, "GE high byte below");
    drive_lsu(word, 1'b0, 4'b0100);
    sample_hits(HIT_EX, "GE high byte equal");
    drive_lsu(word, 1'b0, 4'b1001);
    sample_hits(HIT_EX, "GE high byte above");
    write_csr(CSR_TDATA1, 32'h6000_01C3); // LT
    drive_lsu(word, 1'b0, 4'b1100);
    sample_hits(NO_HIT, "LT low byte equal");
    drive_lsu(word, 1'b0, 4'b1010);
    sample_hits(HIT_EX, "LT low byte below");
    drive_lsu(word, 1'b0, 4'b0000);
    sample_hits(HIT_EX, "LT empty access");
    write_csr(CSR_TDATA1, 32'h6000_0041); // EQ, load only
    drive_lsu(word, 1'b1, 4'b0100);
    sample_hits(NO_HIT, "load only trigger on store");
    drive_lsu(word, 1'b0, 4'b0100);
    sample_hits(HIT_EX, "load only trigger on load");
    clear_requests();
    write_csr(CSR_TDATA1, 0);
    write_csr(CSR_TSELECT, 0);
  endtask

  task automatic exception_trigger();
    write_csr(CSR_TDATA1, 0);
    write_csr(CSR_TDATA2, 32'h0000_0010); // Code 4 is not implemented
    write_csr(CSR_TDATA1, 32'h5000_0200);
    check_rd(rd_value(0, RST_VAL, 32'h10), "etrigger with unlisted code");
    write_csr(CSR_TDATA2, 32'h0000_0008);
    write_csr(CSR_TDATA1, 32'h5000_0200); // M only
    check_rd(rd_value(0, ETRIG_BASE | 32'h200, 32'h8), "etrigger armed");
    write_csr(CSR_TDATA2, 32'hFFFF_FFFF);
    check_rd(rd_value(0, ETRIG_BASE | 32'h200, dbg_trig_pkg::ETRIG_CODE_MASK),
             "etrigger tdata2 masked");
    drive_exc(1'b1, 11'd3, dbg_trig_pkg::PRIV_LVL_M);
    sample_hits(HIT_WB, "cause 3 in M");
    drive_exc(1'b1, 11'd4, dbg_trig_pkg::PRIV_LVL_M);
    sample_hits(NO_HIT, "cause 4 not enabled");
    drive_exc(1'b1, 11'd11, dbg_trig_pkg::PRIV_LVL_M);
    sample_hits(HIT_WB, "cause 11 in M");
    drive_exc(1'b1, 11'd3, dbg_trig_pkg::PRIV_LVL_U);
    sample_hits(NO_HIT, "cause 3 in U");
    drive_exc(1'b0, 11'd3, dbg_trig_pkg::PRIV_LVL_M);
    sample_hits(NO_HIT, "no exception");
    drive_exc(1'b1, 11'd35, dbg_trig_pkg::PRIV_LVL_M);
    sample_hits(NO_HIT, "cause 35 beyond bitmap");
    drive_exc(1'b1, 11'd3, dbg_trig_pkg::PRIV_LVL_M);
    debug_mode = 1'b1;
    sample_hits(NO_HIT, "cause 3 in debug mode");
    clear_requests();
    write_csr(CSR_TDATA1, 0);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    csr_wr = '0;
    clear_requests();
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_reset_state();
    tselect_and_storage();
    tdata1_legalise();
    instr_addr_match();
    lsu_addr_match();
    exception_trigger();
    $display("errors: readback %0d, hits %0d, total %0d",
             rd_errors, hit_errors, rd_errors + hit_errors);
    if (rd_errors + hit_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("Run hung: no finish after %0d cycles", NUM_TESTS * 200);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
